// ==== multiboot_settings.svh ====
// IPROG sequence length and the fixed Spartan-6 configuration command words
`ifndef MULTIBOOT_SETTINGS_SVH
`define MULTIBOOT_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequence length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Words written per reboot, padding and trailing no-op included
`define IPROG_WORD_COUNT 14

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed command words, normal bit order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus width padding ahead of the sync pattern
`define IPROG_DUMMY_WORD 16'hFFFF
// Sync pattern, high half first
`define IPROG_SYNC_HI 16'hAA99
`define IPROG_SYNC_LO 16'h5566
// Type 1 write headers, one word each, for the multiboot registers
`define IPROG_HDR_GEN1 16'h3261
`define IPROG_HDR_GEN2 16'h3281
`define IPROG_HDR_GEN3 16'h32A1
`define IPROG_HDR_GEN4 16'h32C1
// Type 1 write header for the command register
`define IPROG_HDR_CMD 16'h30A1
// Flash read opcode, sits above the upper address byte
`define IPROG_OPCODE 8'h0B
// Command register value that triggers the reboot
`define IPROG_CMD_IPROG 16'h000E
// Type 1 no-op, flushes the command through
`define IPROG_NOOP 16'h2000

`endif

// ==== multibootPkg.sv ====
// Address, ICAP word, reboot request and ICAP beat types for the multiboot controller
`default_nettype none

package multibootPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scalar types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Byte address of a bitstream in SPI flash
    // Upper byte lands in general-2, lower half in general-1
    typedef logic [23:0] bootAddrT;

    // One configuration command word
    typedef logic [15:0] icapWordT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage-to-stage bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Request from the input side to the sequencer
    typedef struct packed {
        // Single-cycle pulse, begins one IPROG sequence
        logic start;
        // Target address, held stable until the next start
        bootAddrT addr;
    } rebootCmdT;

    // One word from the sequencer to the output side
    typedef struct packed {
        // Word is written to the port this cycle
        logic valid;
        // Command word, still in normal bit order
        icapWordT data;
    } icapBeatT;

endpackage

`default_nettype wire

// ==== rebootRequest.sv ====
// Reboot request stage: rising-edge detect, busy gating and target address latch
`default_nettype none

module rebootRequest (
    input  logic                    clk,
    input  logic                    arstN,
    // Synchronous reboot level from the user logic
    input  logic                    reboot,
    input  multibootPkg::bootAddrT  bootAddr,
    // High while the sequencer issues words
    input  logic                    busy,
    output multibootPkg::rebootCmdT cmd
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Edge detect and start pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Previous sample of the reboot level
    logic rebootQ;
    // Registered start pulse
    logic startQ;
    // Latched target address
    logic [23:0] addrQ;
    // Request accepted at this edge
    logic accept;

    // Rising edge of reboot while the sequencer is idle
    // A level held high gives one edge only
    assign accept = reboot && !rebootQ && !busy;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rebootQ <= 1'b0;
            startQ  <= 1'b0;
        end else begin
            rebootQ <= reboot;
            // Start lasts exactly one cycle
            startQ  <= accept;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address latch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Captured at the same edge as the start pulse
    // Later changes of bootAddr leave a running sequence alone
    always_ff @(posedge clk) begin
        if (accept) begin
            addrQ <= bootAddr;
        end
    end

    // Bundle toward the sequencer
    assign cmd.start = startQ;
    assign cmd.addr  = addrQ;

endmodule

`default_nettype wire

// ==== iprogSequencer.sv ====
// IPROG sequencer: steps through the fourteen command words with the boot address inserted
`include "multiboot_settings.svh"
`default_nettype none

module iprogSequencer (
    input  logic                    clk,
    input  logic                    arstN,
    // Start pulse and target address from the request stage
    input  multibootPkg::rebootCmdT cmd,
    // One word per cycle toward the output side
    output multibootPkg::icapBeatT  beat,
    // High exactly while beats are valid
    output logic                    busy
);

    import multibootPkg::*;

    // Index width for the word counter
    localparam int unsigned IdxW = $clog2(`IPROG_WORD_COUNT);
    // Index of the final no-op
    localparam logic [IdxW-1:0] LastIdx = IdxW'(`IPROG_WORD_COUNT - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequence state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Sequence in progress
    logic active;
    // Current word index, 0 to 13
    logic [IdxW-1:0] idx;
    // Private copy of the address for this sequence
    bootAddrT addrQ;
    // Word selected for the current index
    icapWordT word;

    // The request stage only starts while idle, so no busy test here
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (cmd.start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active) begin
            // Stop after the no-op, otherwise advance one word
            if (idx == LastIdx) begin
                active <= 1'b0;
                idx    <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // Address copy loads with the index
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            addrQ <= cmd.addr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Word table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (int'(idx))
            // Padding, then sync
            0:  word = `IPROG_DUMMY_WORD;
            1:  word = `IPROG_SYNC_HI;
            2:  word = `IPROG_SYNC_LO;
            // General-1 takes the lower address half
            3:  word = `IPROG_HDR_GEN1;
            4:  word = addrQ[15:0];
            // General-2 takes opcode and upper address byte
            5:  word = `IPROG_HDR_GEN2;
            6:  word = {`IPROG_OPCODE, addrQ[23:16]};
            // Fallback address fields, golden image at zero
            7:  word = `IPROG_HDR_GEN3;
            8:  word = 16'h0000;
            9:  word = `IPROG_HDR_GEN4;
            10: word = {`IPROG_OPCODE, 8'h00};
            // Command register write, IPROG, flush
            11: word = `IPROG_HDR_CMD;
            12: word = `IPROG_CMD_IPROG;
            13: word = `IPROG_NOOP;
            default: word = '0;
        endcase
    end

    // First beat appears the cycle after start
    assign beat.valid = active;
    assign beat.data  = word;
    assign busy       = active;

endmodule

`default_nettype wire

// ==== icapWriter.sv ====
// ICAP output stage: byte-wise bit swap, registered data and glitch-free active-low strobes
`default_nettype none

module icapWriter (
    input  logic                   clk,
    input  logic                   arstN,
    // Word from the sequencer, normal bit order
    input  multibootPkg::icapBeatT beat,
    // Toward the configuration port, bits reversed in each byte
    output multibootPkg::icapWordT icapData,
    // Active-low chip select
    output logic                   icapCsN,
    // Low for write
    output logic                   icapRdwrN
);

    import multibootPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit swap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Word with each byte mirrored
    icapWordT swapped;
    // Registered output word
    icapWordT dataQ;
    // Shared strobe flop, low while a word is written
    logic strobeNQ;

    // Port expects bit 0 of each byte in the MSB position
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            swapped[i]     = beat.data[7 - i];
            swapped[8 + i] = beat.data[15 - i];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dataQ    <= '0;
            strobeNQ <= 1'b1;
        end else begin
            // Data idles at zero between sequences
            dataQ    <= beat.valid ? swapped : '0;
            strobeNQ <= !beat.valid;
        end
    end

    // Both strobes come from one flop, so they always match
    assign icapData  = dataQ;
    assign icapCsN   = strobeNQ;
    assign icapRdwrN = strobeNQ;

endmodule

`default_nettype wire

// ==== multibootCtrl.sv ====
// Multiboot controller top level: request stage, IPROG sequencer and ICAP writer
`default_nettype none

module multibootCtrl (
    input  logic                   clk,
    input  logic                   arstN,
    // Reboot request level, synchronous to clk
    input  logic                   reboot,
    // Flash address of the bitstream to load
    input  multibootPkg::bootAddrT bootAddr,
    // Configuration port, bit-swapped words
    output multibootPkg::icapWordT icapData,
    output logic                   icapCsN,
    output logic                   icapRdwrN,
    // Sequence in progress
    output logic                   busy
);

    import multibootPkg::*;

    // Request toward the sequencer
    rebootCmdT cmd;
    // Word stream toward the writer
    icapBeatT  beat;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Edge detect, gated by busy
    rebootRequest uRequest (
        .clk      (clk),
        .arstN    (arstN),
        .reboot   (reboot),
        .bootAddr (bootAddr),
        .busy     (busy),
        .cmd      (cmd)
    );

    // Fourteen words, one per cycle
    iprogSequencer uSequencer (
        .clk   (clk),
        .arstN (arstN),
        .cmd   (cmd),
        .beat  (beat),
        .busy  (busy)
    );

    // Registered port drive
    icapWriter uWriter (
        .clk       (clk),
        .arstN     (arstN),
        .beat      (beat),
        .icapData  (icapData),
        .icapCsN   (icapCsN),
        .icapRdwrN (icapRdwrN)
    );

endmodule

`default_nettype wire

// ==== multibootCtrlTb.sv ====
// Testbench for the multiboot controller with clock, reset, ICAP port model, stimulus, assertions and report
`include "multiboot_settings.svh"
`default_nettype none

module multibootCtrlTb;

    timeunit 1ns;
    timeprecision 100ps;

    import multibootPkg::*;

    // Six tests of roughly 40 cycles each plus margin
    localparam int TestCycles = 40;
    localparam int CycleLimit = 6 * TestCycles + 160;
    localparam int TestCount = 6;

    // DUT connections
    logic     clk;
    logic     arstN;
    logic     reboot;
    bootAddrT bootAddr;
    icapWordT icapData;
    logic     icapCsN;
    logic     icapRdwrN;
    logic     busy;

    // Port model state
    icapWordT portWord;
    int       wordCount = 0;
    int       seqCount = 0;

    // Reference words for the running sequence
    icapWordT expWords [`IPROG_WORD_COUNT];
    icapWordT expWord;
    icapWordT expSwapped;
    int       seqExpected = 0;
    logic     checkpoint;
    logic     requested;

    // Bookkeeping
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    bootAddrT    addrA;
    bootAddrT    addrB;

    multibootCtrl dut (
        .clk       (clk),
        .arstN     (arstN),
        .reboot    (reboot),
        .bootAddr  (bootAddr),
        .icapData  (icapData),
        .icapCsN   (icapCsN),
        .icapRdwrN (icapRdwrN),
        .busy      (busy)
    );

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Mirror the bits inside each byte
    // Applying it twice restores the word
    function automatic icapWordT mirrorBytes(input icapWordT w);
        logic [7:0] hi;
        logic [7:0] lo;
        hi = {<<{w[15:8]}};
        lo = {<<{w[7:0]}};
        return {hi, lo};
    endfunction

    function automatic bootAddrT randomAddr();
        logic [31:0] r;
        r = $urandom();
        return r[23:0];
    endfunction

    // IPROG word list for one target address
    task automatic loadExpected(input bootAddrT addr);
        expWords[0]  = `IPROG_DUMMY_WORD;
        expWords[1]  = `IPROG_SYNC_HI;
        expWords[2]  = `IPROG_SYNC_LO;
        expWords[3]  = `IPROG_HDR_GEN1;
        expWords[4]  = addr[15:0];
        expWords[5]  = `IPROG_HDR_GEN2;
        expWords[6]  = {`IPROG_OPCODE, addr[23:16]};
        expWords[7]  = `IPROG_HDR_GEN3;
        expWords[8]  = 16'h0000;
        expWords[9]  = `IPROG_HDR_GEN4;
        expWords[10] = {`IPROG_OPCODE, 8'h00};
        expWords[11] = `IPROG_HDR_CMD;
        expWords[12] = `IPROG_CMD_IPROG;
        expWords[13] = `IPROG_NOOP;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        errorCount++;
        $display("error %s: got %0h expected %0h", name, got, want);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("%s", what);
    endtask

    // Load the reference words and pulse reboot for one cycle
    task automatic pulseReboot(input bootAddrT addr);
        loadExpected(addr);
        @(posedge clk);
        reboot      <= 1'b1;
        bootAddr    <= addr;
        requested   <= 1'b1;
        seqExpected <= seqExpected + 1;
        @(posedge clk);
        reboot <= 1'b0;
    endtask

    // Wait for the strobes to fall and rise again after the last word
    task automatic waitSequenceEnd();
        do @(negedge clk); while (icapCsN);
        do @(negedge clk); while (!icapCsN);
    endtask

    // Checkpoint pulse samples the sequence count
    task automatic endTest(input string name);
        @(posedge clk);
        checkpoint <= 1'b1;
        @(posedge clk);
        checkpoint <= 1'b0;
        @(posedge clk);
        if (errorCount == testErrors) begin
            testsPassed++;
            $display("test %s: passed", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Port model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Undo the byte-wise swap on the captured word
    assign portWord   = mirrorBytes(icapData);
    assign expWord    = expWords[wordCount];
    assign expSwapped = mirrorBytes(expWord);

    // Count words while chip select is low and restart when it rises
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wordCount <= 0;
            seqCount  <= 0;
        end else if (!icapCsN) begin
            if (wordCount == 0) begin
                seqCount <= seqCount + 1;
            end
            wordCount <= wordCount + 1;
        end else begin
            wordCount <= 0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Assertions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Outputs at their reset values until the first request
    idleCsN: assert property (@(posedge clk) disable iff (!arstN)
        !requested |-> icapCsN)
        else reportMismatch("icapCsN", $sampled(icapCsN), 1);
    idleRdwrN: assert property (@(posedge clk) disable iff (!arstN)
        !requested |-> icapRdwrN)
        else reportMismatch("icapRdwrN", $sampled(icapRdwrN), 1);
    idleBusy: assert property (@(posedge clk) disable iff (!arstN)
        !requested |-> !busy)
        else reportMismatch("busy", $sampled(busy), 0);

    strobesMatch: assert property (@(posedge clk) disable iff (!arstN)
        icapCsN == icapRdwrN)
        else reportMismatch("icapRdwrN", $sampled(icapRdwrN), $sampled(icapCsN));

    dataZeroWhenIdle: assert property (@(posedge clk) disable iff (!arstN)
        icapCsN |-> icapData == 16'h0000)
        else reportMismatch("icapData", $sampled(icapData), 0);

    // Strobes trail busy by exactly one cycle
    strobeFollowsBusy: assert property (@(posedge clk) disable iff (!arstN)
        busy |=> !icapCsN)
        else reportFailure("chip select stayed high after busy was high");
    strobeFollowsIdle: assert property (@(posedge clk) disable iff (!arstN)
        !busy |=> icapCsN)
        else reportFailure("chip select went low while busy was low");

    // First word two cycles after the sampled rising edge of reboot
    startLatency: assert property (@(posedge clk) disable iff (!arstN)
        $fell(icapCsN) |-> ($past(reboot, 3) && !$past(reboot, 4)))
        else reportFailure("first word did not follow a reboot rising edge by 2 cycles");

    portWordCheck: assert property (@(posedge clk) disable iff (!arstN)
        !icapCsN |-> portWord == expWord)
        else reportMismatch("portWord", $sampled(portWord), $sampled(expWord));

    swappedDataCheck: assert property (@(posedge clk) disable iff (!arstN)
        !icapCsN |-> icapData == expSwapped)
        else reportMismatch("icapData", $sampled(icapData), $sampled(expSwapped));

    wordCountCheck: assert property (@(posedge clk) disable iff (!arstN)
        $rose(icapCsN) |-> wordCount == `IPROG_WORD_COUNT)
        else reportMismatch("wordCount", $sampled(wordCount), `IPROG_WORD_COUNT);

    sequenceCountCheck: assert property (@(posedge clk) disable iff (!arstN)
        checkpoint |-> seqCount == seqExpected)
        else reportMismatch("seqCount", $sampled(seqCount), $sampled(seqExpected));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("timeout after %0d cycles, the tests did not complete", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(78));
        arstN      = 1'b0;
        reboot     = 1'b0;
        bootAddr   = '0;
        requested  = 1'b0;
        checkpoint = 1'b0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;

        // Outputs idle before any request
        repeat (6) @(posedge clk);
        endTest("reset idle");

        addrA = randomAddr();
        pulseReboot(addrA);
        waitSequenceEnd();
        endTest("single sequence");

        // Fresh address for the byte swap seen on icapData
        addrA = randomAddr();
        pulseReboot(addrA);
        waitSequenceEnd();
        endTest("bit swap");

        // Level held high with a fresh edge while busy
        addrA = randomAddr();
        loadExpected(addrA);
        @(posedge clk);
        reboot      <= 1'b1;
        bootAddr    <= addrA;
        seqExpected <= seqExpected + 1;
        repeat (6) @(posedge clk);
        reboot <= 1'b0;
        @(posedge clk);
        reboot <= 1'b1;
        repeat (23) @(posedge clk);
        reboot <= 1'b0;
        repeat (4) @(posedge clk);
        endTest("held level");

        // Address moves mid-sequence to its bitwise complement
        addrA = randomAddr();
        addrB = addrA ^ 24'hFFFFFF;
        pulseReboot(addrA);
        repeat (3) @(posedge clk);
        bootAddr <= addrB;
        waitSequenceEnd();
        endTest("address change");

        addrA = randomAddr();
        addrB = randomAddr();
        pulseReboot(addrA);
        waitSequenceEnd();
        pulseReboot(addrB);
        waitSequenceEnd();
        endTest("back to back");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 TestCount, testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== multibootCtrl.f ====
+incdir+.
multibootPkg.sv
rebootRequest.sv
iprogSequencer.sv
icapWriter.sv
multibootCtrl.sv
multibootCtrlTb.sv

// ==== Makefile ====
# Verilator build and run for the multiboot controller testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = multibootCtrlTb
FILELIST  = multibootCtrl.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = TEST PASS

SOURCES = $(shell grep -v '^+' $(FILELIST)) multiboot_settings.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass or fail comes from the log, not the simulator exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
